/* common/fifoGeomPkg.sv */
//--------------------------------------------------------------------
// FIFO geometry shared by the RTL and the bench
// depth, pointer width and the pointer type, imported by wildcard
//--------------------------------------------------------------------
`default_nettype none

package fifoGeomPkg;

    //--------------------------------------------------------------------
    // storage geometry
    //--------------------------------------------------------------------
    // number of RAM slots, must stay a power of two
    // Gray wrap is only one bit wide for 2**n
    localparam int cBuffDepth = 16;

    // address bits, log2 of the depth
    localparam int cAddrWidth = $clog2(cBuffDepth);

    // one slot kept free so full != empty
    localparam int cCapacity  = cBuffDepth - 1;     // usable words

    //--------------------------------------------------------------------
    // pointer type
    //--------------------------------------------------------------------
    // same width for binary count, Gray copy and RAM address
    // no extra wrap bit, the free slot separates full from empty
    typedef logic [cAddrWidth-1:0] ptrT;

endpackage : fifoGeomPkg

`default_nettype wire

/* common/fifoDataPkg.sv */
//--------------------------------------------------------------------
// payload description for the FIFO stream
// word width and word type, imported by RTL and bench alike
//--------------------------------------------------------------------
`default_nettype none

package fifoDataPkg;

    // stream word width in bits
    localparam int cBitWidth = 32;

    // one word as stored in the RAM and shown on oRD
    typedef logic [cBitWidth-1:0] wordT;

endpackage : fifoDataPkg

`default_nettype wire

/* fifo/userFifoDual.sv */
//--------------------------------------------------------------------
// distributed RAM behind the dual-clock FIFO
// synchronous write in iCLKA, asynchronous read, zero read latency
//--------------------------------------------------------------------
`default_nettype none

module userFifoDual
    import fifoGeomPkg::*, fifoDataPkg::*;
(
    input  wire logic iCLKA,    // write clock
    input  wire wordT iWD,      // write data
    input  wire ptrT  iWA,      // write address, binary
    input  wire logic iWE,      // write strobe, already qualified
    input  wire ptrT  iRA,      // read address, from the iCLKB side
    output wordT      oRD       // word at iRA, no clock
);

    //--------------------------------------------------------------------
    // storage array
    //--------------------------------------------------------------------
    // small enough to map onto LUTs, read port stays combinational
    // contents are don't-care until written
    wordT mem [0:cBuffDepth-1];

    //--------------------------------------------------------------------
    // write port
    //--------------------------------------------------------------------
    always_ff @(posedge iCLKA)
    begin
        if (iWE)
        begin
            mem[iWA] <= iWD;    // one word per edge
        end
    end

    //--------------------------------------------------------------------
    // read port
    //--------------------------------------------------------------------
    // iRA only moves after the slot is known written,
    // the Gray crossing guarantees that ordering
    assign oRD = mem[iRA];

endmodule : userFifoDual

`default_nettype wire

/* fifo/grayPtrSync.sv */
//--------------------------------------------------------------------
// brings a Gray pointer into another clock domain
// two flops in the destination clock, then back to binary
// one instance per direction inside the FIFO top
//--------------------------------------------------------------------
`default_nettype none

module grayPtrSync
    import fifoGeomPkg::*;
(
    input  wire logic iCLKB,    // destination clock
    input  wire logic iRSTB,    // destination reset, sync active high
    input  wire ptrT  iGray,    // Gray pointer, registered in source clock
    output ptrT       oBin      // binary pointer in destination clock
);

    //--------------------------------------------------------------------
    // synchronizer stages
    //--------------------------------------------------------------------
    ptrT syncMeta;      // first stage, may go metastable
    ptrT syncGray;      // second stage, settled Gray value
    ptrT binVal;        // decoded count

    always_ff @(posedge iCLKB)
    begin
        if (iRSTB)
        begin
            syncMeta <= '0;
            syncGray <= '0;
        end
        else
        begin
            syncMeta <= iGray;      // async capture
            syncGray <= syncMeta;   // resolve
        end
    end

    //--------------------------------------------------------------------
    // Gray to binary
    //--------------------------------------------------------------------
    // XOR prefix from the top bit down,
    // each binary bit is the parity of all Gray bits at or above it
    always_comb
    begin
        binVal[cAddrWidth-1] = syncGray[cAddrWidth-1];
        for (int i = cAddrWidth - 2; i >= 0; i--)
        begin
            binVal[i] = binVal[i+1] ^ syncGray[i];
        end
    end

    assign oBin = binVal;   // compared against the local pointer

endmodule : grayPtrSync

`default_nettype wire

/* fifo/fifoDualController.sv */
//--------------------------------------------------------------------
// dual-clock FIFO top, producer on iCLKA and consumer on iCLKB
// pointers cross in Gray code through two-flop synchronizers
// first-word fall-through, oRD holds the oldest word while oEMP is low
//--------------------------------------------------------------------
`default_nettype none

module fifoDualController
    import fifoGeomPkg::*, fifoDataPkg::*;
(
    input  wire logic iCLKA,       // write side clock
    input  wire logic iCLKB,       // read side clock
    input  wire logic iRSTA,       // write side reset, sync active high
    input  wire logic iRSTB,       // read side reset, sync active high
    input  wire wordT iWD,         // write data
    input  wire logic iWE,         // write strobe, dropped while full
    output logic      oFLL,        // no free slot seen by the writer
    output wordT      oRD,         // oldest word, combinational
    input  wire logic iRE,         // read strobe, ignored while empty
    output logic      oRVD,        // word on oRD consumed this edge
    output logic      oEMP         // nothing to read seen by the reader
);

    //--------------------------------------------------------------------
    // Gray encoding
    //--------------------------------------------------------------------
    // adjacent counts differ in one bit, so a pointer sampled
    // mid-change in the other clock is either old or new, never junk
    function automatic ptrT toGray(input ptrT bin);
        return bin ^ (bin >> 1);
    endfunction

    //--------------------------------------------------------------------
    // write domain signals (iCLKA)
    //--------------------------------------------------------------------
    ptrT  wrBin;        // binary write count, also RAM write address
    ptrT  wrBinInc;     // wrBin plus one
    ptrT  wrBinNext;    // value loaded at the next iCLKA edge
    ptrT  wrGray;       // registered Gray copy, the only thing that crosses
    ptrT  rdBinSync;    // read pointer as seen in iCLKA
    logic full;         // next write would land on the read slot
    logic wrEn;         // qualified write strobe

    //--------------------------------------------------------------------
    // read domain signals (iCLKB)
    //--------------------------------------------------------------------
    ptrT  rdBin;        // binary read count, also RAM read address
    ptrT  rdBinNext;    // value loaded at the next iCLKB edge
    ptrT  rdGray;       // registered Gray copy for the writer
    ptrT  wrBinSync;    // write pointer as seen in iCLKB
    logic empty;        // read pointer caught up with writes seen so far
    logic rdEn;         // qualified read strobe

    //--------------------------------------------------------------------
    // write side
    //--------------------------------------------------------------------
    assign wrBinInc = ptrT'(wrBin + 1'b1);

    // full when one more write would make the pointers equal,
    // rdBinSync lags the reader so this can only be early, never late
    assign full = (wrBinInc == rdBinSync);

    // writes while full are lost on purpose
    assign wrEn = iWE & ~full;

    assign wrBinNext = wrEn ? wrBinInc : wrBin;

    always_ff @(posedge iCLKA)
    begin
        if (iRSTA)
        begin
            wrBin  <= '0;
            wrGray <= '0;               // Gray of zero is zero
        end
        else
        begin
            wrBin  <= wrBinNext;
            // Gray taken from the next count so it moves
            // on the same edge as the RAM write
            wrGray <= toGray(wrBinNext);
        end
    end

    //--------------------------------------------------------------------
    // read side
    //--------------------------------------------------------------------
    // empty when nothing written beyond what was already read,
    // wrBinSync lags the writer so empty clears late, never early
    assign empty = (rdBin == wrBinSync);

    // strobe valid only with data present, no reset term here
    assign rdEn = iRE & ~empty;

    assign rdBinNext = rdEn ? ptrT'(rdBin + 1'b1) : rdBin;

    always_ff @(posedge iCLKB)
    begin
        if (iRSTB)
        begin
            rdBin  <= '0;
            rdGray <= '0;
        end
        else
        begin
            rdBin  <= rdBinNext;
            rdGray <= toGray(rdBinNext);    // freed slot visible to writer
        end
    end

    //--------------------------------------------------------------------
    // flags out
    //--------------------------------------------------------------------
    assign oFLL = full;
    assign oEMP = empty;
    assign oRVD = rdEn;                 // same term that bumps rdBin

    //--------------------------------------------------------------------
    // storage
    //--------------------------------------------------------------------
    // LUT RAM, written in iCLKA, read asynchronously at rdBin
    userFifoDual uFifoRam
    (
        .iCLKA (iCLKA),
        .iWD   (iWD),
        .iWA   (wrBin),
        .iWE   (wrEn),
        .iRA   (rdBin),
        .oRD   (oRD)
    );

    //--------------------------------------------------------------------
    // pointer crossings
    //--------------------------------------------------------------------
    // write pointer into the read clock, feeds empty
    grayPtrSync uSyncWr2Rd
    (
        .iCLKB (iCLKB),
        .iRSTB (iRSTB),
        .iGray (wrGray),
        .oBin  (wrBinSync)
    );

    // read pointer into the write clock, feeds full
    // destination here is iCLKA, so the write side clock and reset
    grayPtrSync uSyncRd2Wr
    (
        .iCLKB (iCLKA),
        .iRSTB (iRSTA),
        .iGray (rdGray),
        .oBin  (rdBinSync)
    );

endmodule : fifoDualController

`default_nettype wire

/* bench/fifoProperties.sv */
//----------------------------------------------------------------------
// concurrent assertions bound into the dual-clock FIFO top
// held read data, reset value and one-bit steps of the Gray pointers
//----------------------------------------------------------------------
`default_nettype none

module fifoProperties
    import fifoGeomPkg::*, fifoDataPkg::*;
(
    input wire logic iCLKA,
    input wire logic iCLKB,
    input wire logic iRSTA,
    input wire logic iRSTB,
    input wire logic oRVD,
    input wire logic oEMP,
    input wire wordT oRD,
    input wire ptrT  wrGray,        // write pointer Gray copy before the crossing
    input wire ptrT  rdBinSync      // read pointer after the crossing
);

    timeunit 1ns;
    timeprecision 100ps;

    ptrT rdSyncGray;    // Gray view of the synchronized read pointer

    assign rdSyncGray = rdBinSync ^ (rdBinSync >> 1);

    //----------------------------------------------------------------------
    // read side
    //----------------------------------------------------------------------
    // a waiting word stays on oRD until it is read
    aHoldUnread : assert property (@(posedge iCLKB) disable iff (iRSTB)
        (!oEMP && !oRVD) |=> $stable(oRD))
        else $error("oRD changed while its word was still unread");

    aEmptyAfterReset : assert property (@(posedge iCLKB)
        iRSTB |=> oEMP)
        else $error("oEMP low in the cycle after iRSTB");

    //----------------------------------------------------------------------
    // write side
    //----------------------------------------------------------------------
    // the write count steps one Gray code per iCLKA edge at most
    // the slower reader may see two steps at once
    aWrGrayOneBit : assert property (@(posedge iCLKA) disable iff (iRSTA)
        $countones(wrGray ^ $past(wrGray)) <= 1)
        else $error("write pointer Gray copy changed in more than one bit");

    // iCLKA outruns iCLKB so the read pointer arrives one code at a time
    aRdSyncOneBit : assert property (@(posedge iCLKA) disable iff (iRSTA)
        $countones(rdSyncGray ^ $past(rdSyncGray)) <= 1)
        else $error("synchronized read pointer changed in more than one bit");

endmodule : fifoProperties

bind fifoDualController fifoProperties uProps
(
    .iCLKA     (iCLKA),
    .iCLKB     (iCLKB),
    .iRSTA     (iRSTA),
    .iRSTB     (iRSTB),
    .oRVD      (oRVD),
    .oEMP      (oEMP),
    .oRD       (oRD),
    .wrGray    (wrGray),
    .rdBinSync (rdBinSync)
);

`default_nettype wire

/* bench/fifoChecker.sv */
//----------------------------------------------------------------------
// scoreboard for the dual-clock FIFO
// logs accepted writes in iCLKA and checks every valid read in iCLKB
// also answers flag checks requested by the testbench
//----------------------------------------------------------------------
`default_nettype none

module fifoChecker
    import fifoGeomPkg::*, fifoDataPkg::*;
(
    input  wire logic           iCLKA,
    input  wire logic           iCLKB,
    input  wire logic           iRSTB,
    input  wire wordT           iWD,
    input  wire logic           iWE,
    input  wire logic           oFLL,
    input  wire wordT           oRD,
    input  wire logic           oRVD,
    input  wire logic           oEMP,
    input  wire logic [127:0]   rowName,        // current test name as packed text
    input  wire logic           checkReset,     // flag values after reset
    input  wire logic           checkFull,      // full after a held-off fill
    input  wire logic           checkDrain,     // nothing left after a drain
    output int                  mismatchCnt,
    output int                  otherCnt
);

    timeunit 1ns;
    timeprecision 100ps;

    wordT expLog [int];     // accepted writes in write order
    int   wrIdx   = 0;      // next log slot and accepted write count
    int   rdIdx   = 0;      // oldest word not yet read
    int   baseIdx = 0;      // wrIdx at the start of the current row

    task automatic reportMismatch(input string what, input wordT expVal, input wordT actVal);
        mismatchCnt++;
        $display("Mismatch %0s: %0s expected 0x%h actual 0x%h", rowName, what, expVal, actVal);
    endtask

    //----------------------------------------------------------------------
    // write side
    //----------------------------------------------------------------------
    always @(posedge iCLKA)
    begin
        if (iWE && !oFLL)
        begin
            expLog[wrIdx] = iWD;
            wrIdx++;
        end
    end

    //----------------------------------------------------------------------
    // read side
    //----------------------------------------------------------------------
    always @(posedge iCLKB)
    begin
        if (!iRSTB)
        begin
            if (oRVD)
            begin
                if (rdIdx >= wrIdx)
                begin
                    otherCnt++;     // nothing was ever written for this one
                    $display("Error %0s: valid read from an empty FIFO", rowName);
                end
                else
                begin
                    if (oRD !== expLog[rdIdx])
                    begin
                        reportMismatch("read data", expLog[rdIdx], oRD);
                    end
                    rdIdx++;
                end
            end
            if (checkReset)
            begin
                if (oEMP !== 1'b1) reportMismatch("oEMP", 1, wordT'(oEMP));
                if (oFLL !== 1'b0) reportMismatch("oFLL", 0, wordT'(oFLL));
                if (oRVD !== 1'b0) reportMismatch("oRVD", 0, wordT'(oRVD));
            end
            if (checkFull)
            begin
                // reads held off so every slot but the spare one is taken
                if (oFLL !== 1'b1) reportMismatch("oFLL", 1, wordT'(oFLL));
                if (wrIdx - baseIdx != cCapacity)
                begin
                    reportMismatch("accepted writes", cCapacity, wrIdx - baseIdx);
                end
            end
            if (checkDrain)
            begin
                if (wrIdx != rdIdx) reportMismatch("words left", 0, wrIdx - rdIdx);
                baseIdx = wrIdx;    // next row counts from here
            end
        end
    end

endmodule : fifoChecker

`default_nettype wire

/* bench/tbFifoDual.sv */
//----------------------------------------------------------------------
// testbench for the dual-clock FIFO
// walks a table of write/read duty cycles and drains after each row
// comparing is done in fifoChecker
// assertions come in by bind
//----------------------------------------------------------------------
`default_nettype none

module tbFifoDual
    import fifoGeomPkg::*, fifoDataPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [8*16-1:0] nameT;     // up to 16 chars

    typedef struct {
        nameT name;
        int   attempts;     // cycles with iWE high
        int   wrDuty;       // percent of iCLKA cycles with a write
        int   rdDuty;       // percent of iCLKB cycles with a read
        bit   holdReads;    // no reads until the writes are done
    } rowT;

    logic iCLKA = 1'b0;
    logic iCLKB = 1'b0;
    logic iRSTA;
    logic iRSTB;
    wordT iWD;
    logic iWE;
    logic oFLL;
    wordT oRD;
    logic iRE;
    logic oRVD;
    logic oEMP;

    nameT rowName;
    logic checkReset;
    logic checkFull;
    logic checkDrain;
    int   mismatchCnt;
    int   otherCnt;

    rowT  rows [5];
    logic writesDone;   // write process finished its row
    int   cycleCnt   = 0;
    int   cycleLimit = 0;

    always #14 iCLKA = ~iCLKA;      // 28 ns period drifting against iCLKB
    always #20 iCLKB = ~iCLKB;      // 40 ns

    fifoDualController uut
    (
        .iCLKA (iCLKA), .iCLKB (iCLKB), .iRSTA (iRSTA), .iRSTB (iRSTB),
        .iWD   (iWD),   .iWE   (iWE),   .oFLL  (oFLL),  .oRD   (oRD),
        .iRE   (iRE),   .oRVD  (oRVD),  .oEMP  (oEMP)
    );

    fifoChecker chk
    (
        .iCLKA (iCLKA), .iCLKB (iCLKB), .iRSTB (iRSTB), .iWD (iWD), .iWE (iWE),
        .oFLL (oFLL), .oRD (oRD), .oRVD (oRVD), .oEMP (oEMP),
        .rowName (rowName), .checkReset (checkReset), .checkFull (checkFull),
        .checkDrain (checkDrain), .mismatchCnt (mismatchCnt), .otherCnt (otherCnt)
    );

    task automatic printSummary(input int extraErrors);
        $display("mismatches: %0d  other errors: %0d", mismatchCnt, otherCnt + extraErrors);
        if (mismatchCnt == 0 && otherCnt + extraErrors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // which selects 0 reset flags 1 full 2 drained
    // strobe lasts one iCLKB cycle
    task automatic requestCheck(input int which);
        @(posedge iCLKB);
        #2;
        checkReset = (which == 0);
        checkFull  = (which == 1);
        checkDrain = (which == 2);
        @(posedge iCLKB);
        #2;
        checkReset = 1'b0;
        checkFull  = 1'b0;
        checkDrain = 1'b0;
    endtask

    task automatic writeSide(input int attempts, input int duty);
        int sent;
        sent = 0;
        while (sent < attempts)
        begin
            @(posedge iCLKA);
            #2;
            if (($urandom % 100) < duty)
            begin
                iWE  = 1'b1;
                iWD  = $urandom;
                sent++;
            end
            else
            begin
                iWE = 1'b0;
            end
        end
        @(posedge iCLKA);       // last attempt taken here
        #2;
        iWE        = 1'b0;
        writesDone = 1'b1;
    endtask

    task automatic readSide(input int attempts, input int duty, input bit hold);
        bit running;
        running = 1'b1;
        if (hold)
        begin
            while (!writesDone)
            begin
                @(posedge iCLKB);
                #2;
            end
            if (attempts >= cCapacity) requestCheck(1);    // enough writes to fill
        end
        else
        begin
            while (running)
            begin
                @(posedge iCLKB);
                #2;
                if (writesDone) running = 1'b0;
                else iRE = (($urandom % 100) < duty);
            end
            iRE = 1'b0;
        end
    endtask

    // read until oEMP has stayed high for 8 cycles
    task automatic drainFifo();
        int quiet;
        quiet = 0;
        @(posedge iCLKB);
        #2;
        iRE = 1'b1;
        while (quiet < 8)
        begin
            @(posedge iCLKB);
            #2;
            if (oEMP) quiet++;
            else quiet = 0;
        end
        iRE = 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'h82ec402f));
        iRSTA = 1'b1;
        iRSTB = 1'b1;
        iWD = '0;
        iWE = 1'b0;
        iRE = 1'b0;
        checkReset = 1'b0;
        checkFull  = 1'b0;
        checkDrain = 1'b0;
        writesDone = 1'b0;
        rowName = nameT'("reset");

        //----------------------------------------------------------------------
        // name, attempts, write duty, read duty, hold reads
        //----------------------------------------------------------------------
        rows[0] = '{nameT'("random_mix"),  60,  60,  50, 1'b0};
        rows[1] = '{nameT'("fill_full"),   24, 100, 100, 1'b1};   // overfill then drain
        rows[2] = '{nameT'("empty_reads"), 12,  20, 100, 1'b0};   // reader mostly starved
        rows[3] = '{nameT'("stream_full"), 80, 100, 100, 1'b0};
        rows[4] = '{nameT'("bursty"),      40,  90,  30, 1'b0};

        foreach (rows[i]) cycleLimit += rows[i].attempts * 4 + 100;

        repeat (10) @(posedge iCLKB);
        #2;
        iRSTB = 1'b0;
        @(posedge iCLKA);
        #2;
        iRSTA = 1'b0;
        requestCheck(0);

        foreach (rows[i])
        begin
            rowName    = rows[i].name;
            writesDone = 1'b0;
            fork
                writeSide(rows[i].attempts, rows[i].wrDuty);
                readSide(rows[i].attempts, rows[i].rdDuty, rows[i].holdReads);
            join
            drainFifo();
            requestCheck(2);
        end
        printSummary(0);
    end

    // run limit in iCLKB cycles
    always @(posedge iCLKB)
    begin
        cycleCnt++;
        if (cycleLimit > 0 && cycleCnt >= cycleLimit)
        begin
            $display("timeout: FIFO did not drain within %0d cycles", cycleLimit);
            printSummary(1);
        end
    end

endmodule : tbFifoDual

`default_nettype wire

/* all.f */
common/fifoGeomPkg.sv
common/fifoDataPkg.sv
fifo/userFifoDual.sv
fifo/grayPtrSync.sv
fifo/fifoDualController.sv
bench/fifoProperties.sv
bench/fifoChecker.sv
bench/tbFifoDual.sv

/* run.sh */
#!/bin/sh
# build the dual-clock FIFO testbench with Verilator and run it
# exits 0 only when the pass line appears in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tbFifoDual \
    -f all.f \
    -o simFifoDual
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simFifoDual)
simStatus=$?
echo "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Simulation completed successfully"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
